// File: common/src_sram_pkg.sv
// Sizes are fixed here; channel count must stay a power of two so every channel ID is valid
`default_nettype none

package src_sram_pkg;

    // ========================================
    // Sizes
    // ========================================

    // Channels in the controller
    localparam int NUM_CHANNELS = 4;
    // Beat width in bits
    localparam int DATA_WIDTH = 32;
    // Beats of storage per channel
    localparam int SRAM_DEPTH = 16;
    // Holds 0 through SRAM_DEPTH inclusive
    localparam int COUNT_WIDTH = 5;
    // log2 of NUM_CHANNELS
    localparam int CHAN_ID_WIDTH = 2;
    // Allocation and claim request size
    localparam int SIZE_WIDTH = 8;
    // FIFO address, log2 of SRAM_DEPTH
    localparam int PTR_WIDTH = 4;

    // ========================================
    // Vector types
    // ========================================

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [CHAN_ID_WIDTH-1:0] chan_id_t;
    typedef logic [COUNT_WIDTH-1:0]   count_t;
    typedef logic [SIZE_WIDTH-1:0]    size_t;
    typedef logic [PTR_WIDTH-1:0]     ptr_t;

endpackage

`default_nettype wire

// File: channel_unit/space_tracker.sv
// Assumes wr only while fill_ready and pop only while data is presented; outputs lag events by one cycle
`timescale 1ns/1ps
`default_nettype none

module space_tracker (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 alloc_req,
    input  wire src_sram_pkg::size_t  alloc_size,
    input  wire logic                 claim_req,
    input  wire src_sram_pkg::size_t  claim_size,
    input  wire logic                 wr,
    input  wire logic                 pop,
    output logic                      fill_ready,
    output src_sram_pkg::count_t      space_free,
    output src_sram_pkg::count_t      data_avail
);

    // Current counters
    src_sram_pkg::count_t occ_q;
    src_sram_pkg::count_t res_q;
    src_sram_pkg::count_t claim_q;

    // Next-state terms
    src_sram_pkg::count_t occ_d;
    src_sram_pkg::count_t res_dec;
    src_sram_pkg::count_t res_room;
    src_sram_pkg::count_t res_d;
    src_sram_pkg::count_t claim_dec;
    src_sram_pkg::count_t claim_room;
    src_sram_pkg::count_t claim_d;

    // ========================================
    // Counter update
    // ========================================

    always_comb begin
        occ_d = occ_q + src_sram_pkg::count_t'(wr) - src_sram_pkg::count_t'(pop);

        // A write consumes one reserved beat, if any
        res_dec = (wr && res_q != '0) ? res_q - src_sram_pkg::count_t'(1) : res_q;
        // Room left so that space free stays at or above zero
        res_room = src_sram_pkg::count_t'(src_sram_pkg::SRAM_DEPTH) - occ_d - res_dec;
        res_d = res_dec;
        if (alloc_req) begin
            if (alloc_size > src_sram_pkg::size_t'(res_room)) begin
                res_d = res_dec + res_room;
            end else begin
                res_d = res_dec + src_sram_pkg::count_t'(alloc_size);
            end
        end

        // A pop retires one claimed beat, if any
        claim_dec = (pop && claim_q != '0) ? claim_q - src_sram_pkg::count_t'(1) : claim_q;
        // Claims never exceed occupancy
        claim_room = occ_d - claim_dec;
        claim_d = claim_dec;
        if (claim_req) begin
            if (claim_size > src_sram_pkg::size_t'(claim_room)) begin
                claim_d = occ_d;
            end else begin
                claim_d = claim_dec + src_sram_pkg::count_t'(claim_size);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occ_q      <= '0;
            res_q      <= '0;
            claim_q    <= '0;
            space_free <= src_sram_pkg::count_t'(src_sram_pkg::SRAM_DEPTH);
            data_avail <= '0;
        end else begin
            occ_q      <= occ_d;
            res_q      <= res_d;
            claim_q    <= claim_d;
            // Caps above keep both differences non-negative
            space_free <= src_sram_pkg::count_t'(src_sram_pkg::SRAM_DEPTH) - occ_d - res_d;
            data_avail <= occ_d - claim_d;
        end
    end

    // Not full while occupancy is below depth
    assign fill_ready = (occ_q < src_sram_pkg::count_t'(src_sram_pkg::SRAM_DEPTH));

endmodule

`default_nettype wire

// File: channel_unit/channel_fifo.sv
// Writer must respect fill_ready so the FIFO never overflows; rd_data is valid the cycle after rd
`timescale 1ns/1ps
`default_nettype none

module channel_fifo (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 wr,
    input  wire src_sram_pkg::data_t  wr_data,
    input  wire logic                 rd,
    output src_sram_pkg::data_t       rd_data,
    output logic                      empty
);

    // ========================================
    // Storage and pointers
    // ========================================

    src_sram_pkg::data_t mem [src_sram_pkg::SRAM_DEPTH];

    src_sram_pkg::ptr_t   wr_ptr;
    src_sram_pkg::ptr_t   rd_ptr;
    // Beats held, 0 through SRAM_DEPTH
    src_sram_pkg::count_t level;

    // Read only when something is stored
    logic rd_en;

    assign empty = (level == '0);
    assign rd_en = rd & ~empty;

    // Pointers wrap naturally at SRAM_DEPTH
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + src_sram_pkg::ptr_t'(1);
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + src_sram_pkg::ptr_t'(1);
            end
            // Simultaneous write and read leaves level unchanged
            level <= level + src_sram_pkg::count_t'(wr) - src_sram_pkg::count_t'(rd_en);
        end
    end

    // Write port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Registered read port, one cycle of latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: channel_unit/latency_bridge.sv
// Two held beats plus one read in flight at most; out_data is meaningful only while out_valid
`timescale 1ns/1ps
`default_nettype none

module latency_bridge (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 fifo_empty,
    output logic                      fifo_rd,
    input  wire src_sram_pkg::data_t  fifo_data,
    output logic                      out_valid,
    input  wire logic                 out_ready,
    output src_sram_pkg::data_t       out_data
);

    // Held beats, slot 0 is the oldest
    src_sram_pkg::data_t slot0;
    src_sram_pkg::data_t slot1;
    logic [1:0]          held_q;
    // FIFO read issued last cycle, data arrives now
    logic                pending_q;

    logic       pop;
    logic [1:0] held_after_pop;

    assign pop            = out_ready & out_valid;
    assign held_after_pop = held_q - {1'b0, pop};

    // Issue ahead while fewer than two beats are committed
    assign fifo_rd = ~fifo_empty & ((held_after_pop + {1'b0, pending_q}) < 2'd2);

    // ========================================
    // Control state
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            held_q    <= '0;
            pending_q <= 1'b0;
        end else begin
            held_q    <= held_after_pop + {1'b0, pending_q};
            pending_q <= fifo_rd;
        end
    end

    // Data slots; shift on pop, then capture at the first free slot
    always_ff @(posedge clk) begin
        if (pop) begin
            slot0 <= slot1;
        end
        if (pending_q) begin
            if (held_after_pop == 2'd0) begin
                slot0 <= fifo_data;
            end else begin
                slot1 <= fifo_data;
            end
        end
    end

    assign out_valid = (held_q != 2'd0);
    assign out_data  = slot0;

endmodule

`default_nettype wire

// File: channel_unit/src_channel_unit.sv
// One channel; drain_ready is treated as a pop only while drain_valid is high
`timescale 1ns/1ps
`default_nettype none

module src_channel_unit (
    input  wire logic                 clk,
    input  wire logic                 reset,
    // Fill side
    input  wire logic                 fill_valid,
    output logic                      fill_ready,
    input  wire src_sram_pkg::data_t  fill_data,
    input  wire logic                 alloc_req,
    input  wire src_sram_pkg::size_t  alloc_size,
    output src_sram_pkg::count_t      space_free,
    // Drain side
    input  wire logic                 drain_req,
    input  wire src_sram_pkg::size_t  drain_size,
    output src_sram_pkg::count_t      data_avail,
    output logic                      drain_valid,
    input  wire logic                 drain_ready,
    output src_sram_pkg::data_t       drain_data
);

    // Beat accepted into storage this cycle
    logic fill_wr;
    // Beat leaving the bridge this cycle
    logic pop;

    // FIFO to bridge handshake
    logic                fifo_rd;
    logic                fifo_empty;
    src_sram_pkg::data_t fifo_rd_data;

    assign fill_wr = fill_valid & fill_ready;
    assign pop     = drain_ready & drain_valid;

    // Counters; occupancy spans FIFO, read in flight and bridge
    space_tracker u_tracker (
        .clk        (clk),
        .reset      (reset),
        .alloc_req  (alloc_req),
        .alloc_size (alloc_size),
        .claim_req  (drain_req),
        .claim_size (drain_size),
        .wr         (fill_wr),
        .pop        (pop),
        .fill_ready (fill_ready),
        .space_free (space_free),
        .data_avail (data_avail)
    );

    // Storage
    channel_fifo u_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr      (fill_wr),
        .wr_data (fill_data),
        .rd      (fifo_rd),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

    // Hides the registered FIFO read
    latency_bridge u_bridge (
        .clk        (clk),
        .reset      (reset),
        .fifo_empty (fifo_empty),
        .fifo_rd    (fifo_rd),
        .fifo_data  (fifo_rd_data),
        .out_valid  (drain_valid),
        .out_ready  (pop),
        .out_data   (drain_data)
    );

endmodule

`default_nettype wire

// File: source/src_sram_controller.sv
// Raise drain_read only while the addressed drain_valid is high; outputs mux by ID
`timescale 1ns/1ps
`default_nettype none

module src_sram_controller (
    input  wire logic clk,
    input  wire logic reset,

    // Fill allocation from the read engine
    input  wire logic                      fill_alloc_req,
    input  wire src_sram_pkg::size_t       fill_alloc_size,
    input  wire src_sram_pkg::chan_id_t    fill_alloc_id,
    output src_sram_pkg::count_t [src_sram_pkg::NUM_CHANNELS-1:0] fill_space_free,

    // Fill data, one shared port tagged by channel
    input  wire logic                      fill_valid,
    output logic                           fill_ready,
    input  wire src_sram_pkg::chan_id_t    fill_id,
    input  wire src_sram_pkg::data_t       fill_data,

    // Drain flow control from the network master
    output src_sram_pkg::count_t [src_sram_pkg::NUM_CHANNELS-1:0] drain_data_avail,
    input  wire logic [src_sram_pkg::NUM_CHANNELS-1:0]            drain_req,
    input  wire src_sram_pkg::size_t [src_sram_pkg::NUM_CHANNELS-1:0] drain_size,

    // Drain data, one shared read port selected by channel
    output logic [src_sram_pkg::NUM_CHANNELS-1:0] drain_valid,
    input  wire logic                      drain_read,
    input  wire src_sram_pkg::chan_id_t    drain_id,
    output src_sram_pkg::data_t            drain_data
);

    // ========================================
    // Channel decode and output select
    // ========================================

    // One-hot strobes, one bit per channel
    logic [src_sram_pkg::NUM_CHANNELS-1:0] fill_valid_sel;
    logic [src_sram_pkg::NUM_CHANNELS-1:0] alloc_req_sel;
    logic [src_sram_pkg::NUM_CHANNELS-1:0] drain_read_sel;

    // Per-channel results before the ID mux
    logic [src_sram_pkg::NUM_CHANNELS-1:0]               fill_ready_ch;
    src_sram_pkg::data_t [src_sram_pkg::NUM_CHANNELS-1:0] drain_data_ch;

    // Channel count is a power of two, so any ID lands on a real channel
    always_comb begin
        fill_valid_sel = '0;
        alloc_req_sel  = '0;
        drain_read_sel = '0;
        fill_valid_sel[fill_id]       = fill_valid;
        alloc_req_sel[fill_alloc_id]  = fill_alloc_req;
        drain_read_sel[drain_id]      = drain_read;
    end

    // Ready and head beat of the addressed channel
    assign fill_ready = fill_ready_ch[fill_id];
    assign drain_data = drain_data_ch[drain_id];

    // ========================================
    // Channel units
    // ========================================

    for (genvar i = 0; i < src_sram_pkg::NUM_CHANNELS; i++) begin : gen_channel
        src_channel_unit u_channel (
            .clk         (clk),
            .reset       (reset),
            .fill_valid  (fill_valid_sel[i]),
            .fill_ready  (fill_ready_ch[i]),
            .fill_data   (fill_data),
            .alloc_req   (alloc_req_sel[i]),
            .alloc_size  (fill_alloc_size),
            .space_free  (fill_space_free[i]),
            .drain_req   (drain_req[i]),
            .drain_size  (drain_size[i]),
            .data_avail  (drain_data_avail[i]),
            .drain_valid (drain_valid[i]),
            .drain_ready (drain_read_sel[i]),
            .drain_data  (drain_data_ch[i])
        );
    end

endmodule

`default_nettype wire

// File: tests/src_sram_controller_sva.sv
// Sees only top-level ports; drain_read is legal only while the addressed drain_valid is high
`timescale 1ns/1ps
`default_nettype none

module src_sram_controller_sva (
    input wire logic                                                  clk,
    input wire logic                                                  reset,
    input wire logic                                                  fill_ready,
    input wire src_sram_pkg::count_t [src_sram_pkg::NUM_CHANNELS-1:0] fill_space_free,
    input wire src_sram_pkg::count_t [src_sram_pkg::NUM_CHANNELS-1:0] drain_data_avail,
    input wire logic [src_sram_pkg::NUM_CHANNELS-1:0]                 drain_valid,
    input wire logic                                                  drain_read,
    input wire src_sram_pkg::chan_id_t                                drain_id,
    input wire src_sram_pkg::data_t                                   drain_data
);

    // Failure tally, read back at the end of the run
    int error_count = 0;

    // ========================================
    // Reset values
    // ========================================

    // First edge after release, all channels empty with full space
    a_reset_values: assert property (@(posedge clk)
        ($past(reset) && !reset) |->
            (drain_valid == '0) && fill_ready && (drain_data_avail == '0) &&
            (fill_space_free ==
                {src_sram_pkg::NUM_CHANNELS{src_sram_pkg::count_t'(src_sram_pkg::SRAM_DEPTH)}}))
    else begin
        error_count++;
        $error("outputs not at reset values after reset release");
    end

    // ========================================
    // Drain under back-pressure
    // ========================================

    // Held head beat stays put while the same channel is addressed
    a_drain_hold: assert property (@(posedge clk) disable iff (reset)
        ($past(drain_valid[drain_id]) && !$past(drain_read) && $stable(drain_id)) |->
            (drain_valid[drain_id] && $stable(drain_data)))
    else begin
        error_count++;
        $error("drain beat changed while held off");
    end

    // No pop from a channel with nothing presented
    a_read_valid: assert property (@(posedge clk) disable iff (reset)
        drain_read |-> drain_valid[drain_id])
    else begin
        error_count++;
        $error("drain_read raised while drain_valid low");
    end

endmodule

bind src_sram_controller src_sram_controller_sva u_sva (
    .clk              (clk),
    .reset            (reset),
    .fill_ready       (fill_ready),
    .fill_space_free  (fill_space_free),
    .drain_data_avail (drain_data_avail),
    .drain_valid      (drain_valid),
    .drain_read       (drain_read),
    .drain_id         (drain_id),
    .drain_data       (drain_data)
);

`default_nettype wire

// File: tests/tb_src_sram_controller.sv
// Reads tests/src_sram_golden.txt relative to the run directory; stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

module tb_src_sram_controller;

    // ========================================
    // DUT signals
    // ========================================

    logic clk;
    logic reset;

    logic                                                  fill_alloc_req;
    src_sram_pkg::size_t                                   fill_alloc_size;
    src_sram_pkg::chan_id_t                                fill_alloc_id;
    src_sram_pkg::count_t [src_sram_pkg::NUM_CHANNELS-1:0] fill_space_free;
    logic                                                  fill_valid;
    logic                                                  fill_ready;
    src_sram_pkg::chan_id_t                                fill_id;
    src_sram_pkg::data_t                                   fill_data;

    src_sram_pkg::count_t [src_sram_pkg::NUM_CHANNELS-1:0] drain_data_avail;
    logic [src_sram_pkg::NUM_CHANNELS-1:0]                 drain_req;
    src_sram_pkg::size_t [src_sram_pkg::NUM_CHANNELS-1:0]  drain_size;
    logic [src_sram_pkg::NUM_CHANNELS-1:0]                 drain_valid;
    logic                                                  drain_read;
    src_sram_pkg::chan_id_t                                drain_id;
    src_sram_pkg::data_t                                   drain_data;

    src_sram_controller uut (
        .clk              (clk),
        .reset            (reset),
        .fill_alloc_req   (fill_alloc_req),
        .fill_alloc_size  (fill_alloc_size),
        .fill_alloc_id    (fill_alloc_id),
        .fill_space_free  (fill_space_free),
        .fill_valid       (fill_valid),
        .fill_ready       (fill_ready),
        .fill_id          (fill_id),
        .fill_data        (fill_data),
        .drain_data_avail (drain_data_avail),
        .drain_req        (drain_req),
        .drain_size       (drain_size),
        .drain_valid      (drain_valid),
        .drain_read       (drain_read),
        .drain_id         (drain_id),
        .drain_data       (drain_data)
    );

    // 10 ns period
    always #5 clk = ~clk;

    // ========================================
    // Checks and waits
    // ========================================

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after 100 cycles waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    endtask

    // Beats carry first, first+1, ... in order
    task automatic write_beats(input src_sram_pkg::chan_id_t id, input logic [31:0] first,
                               input int count);
        int waited;
        fill_id = id;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            // Ready is sampled half a cycle after fill_id settles
            do begin
                @(negedge clk);
                waited++;
                if (waited > 100) report_timeout("fill_ready");
            end while (!fill_ready);
            fill_data  = first + 32'(i);
            fill_valid = 1'b1;
            @(negedge clk);
            fill_valid = 1'b0;
        end
    endtask

    task automatic pop_beats(input src_sram_pkg::chan_id_t id, input int count,
                             input logic [31:0] first);
        int waited;
        drain_id = id;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > 100) report_timeout("drain_valid");
            end while (!drain_valid[id]);
            check_value($sformatf("drain_data[%0d]", id), drain_data, first + 32'(i));
            drain_read = 1'b1;
            @(negedge clk);
            drain_read = 1'b0;
        end
    endtask

    // One-cycle pulses
    task automatic allocate_space(input src_sram_pkg::chan_id_t id, input logic [31:0] size);
        fill_alloc_id   = id;
        fill_alloc_size = src_sram_pkg::size_t'(size);
        fill_alloc_req  = 1'b1;
        @(negedge clk);
        fill_alloc_req  = 1'b0;
    endtask

    task automatic claim_beats(input src_sram_pkg::chan_id_t id, input logic [31:0] size);
        drain_size[id] = src_sram_pkg::size_t'(size);
        drain_req[id]  = 1'b1;
        @(negedge clk);
        drain_req      = '0;
    endtask

    // Drain held off, head beat stays addressed for the bound checker
    task automatic hold_drain(input src_sram_pkg::chan_id_t id, input int cycles);
        drain_id   = id;
        drain_read = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // ========================================
    // Golden-file dispatch
    // ========================================

    task automatic run_op(input byte op, input int ch, input logic [31:0] val,
                          input logic [31:0] exp);
        src_sram_pkg::chan_id_t id;
        id = src_sram_pkg::chan_id_t'(ch);
        case (op)
            "A": allocate_space(id, val);
            "W": write_beats(id, val, int'(exp));
            "C": claim_beats(id, val);
            "R": pop_beats(id, int'(val), exp);
            "H": hold_drain(id, int'(val));
            "S": check_value($sformatf("fill_space_free[%0d]", ch),
                             32'(fill_space_free[id]), exp);
            "V": check_value($sformatf("drain_data_avail[%0d]", ch),
                             32'(drain_data_avail[id]), exp);
            "B": begin
                fill_id = id;
                @(negedge clk);
                check_value($sformatf("fill_ready[%0d]", ch), 32'(fill_ready), exp);
            end
            default: begin
                $display("Unknown operation letter in the golden file");
                $display("TEST FAILED");
                $fatal(1, "bad vector");
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          rc;
        string       line;
        byte         op;
        int          ch;
        logic [31:0] val;
        logic [31:0] exp;

        clk             = 1'b0;
        reset           = 1'b1;
        fill_alloc_req  = 1'b0;
        fill_alloc_size = '0;
        fill_alloc_id   = '0;
        fill_valid      = 1'b0;
        fill_id         = '0;
        fill_data       = '0;
        drain_req       = '0;
        drain_size      = '0;
        drain_read      = 1'b0;
        drain_id        = '0;

        // Ten rising edges under reset
        repeat (10) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("tests/src_sram_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            $display("TEST FAILED");
            $fatal(1, "missing vectors");
        end

        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            rc = $sscanf(line, "%c %d %h %h", op, ch, val, exp);
            if (rc != 4) begin
                $display("Malformed line in the golden file: %s", line);
                $display("TEST FAILED");
                $fatal(1, "bad vector");
            end
            run_op(op, ch, val, exp);
        end
        $fclose(fd);

        @(negedge clk);
        if (uut.u_sva.error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", uut.u_sva.error_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: tests/src_sram_golden.txt
# op ch value expect; ch decimal, value and expect hex. W: value is first data, expect beat count
# R: value is beat count, expect first data. A/C: value is size. H: value is cycles. S/V/B: expect
S 0 0 10
S 1 0 10
S 2 0 10
S 3 0 10
V 0 0 0
V 1 0 0
V 2 0 0
V 3 0 0
B 0 0 1
A 1 5 0
S 1 0 b
W 1 a1 3
S 1 0 b
A 1 28 0
S 1 0 0
W 0 b01 1
W 2 c01 1
W 3 d01 1
W 0 b02 1
W 2 c02 1
W 3 d02 1
R 3 1 d01
R 0 1 b01
R 2 1 c01
R 0 1 b02
R 3 1 d02
R 2 1 c02
V 0 0 0
W 2 c03 3
V 2 0 3
C 2 2 0
V 2 0 1
R 2 1 c03
V 2 0 1
C 2 9 0
V 2 0 0
R 2 2 c04
W 3 e00 10
B 3 0 0
V 3 0 10
S 3 0 0
R 3 1 e00
B 3 0 1
W 3 e10 1
B 3 0 0
H 3 14 0
R 3 10 e01
V 3 0 0
S 3 0 10
R 1 3 a1
S 1 0 3
V 1 0 0

// File: all.f
common/src_sram_pkg.sv
channel_unit/space_tracker.sv
channel_unit/channel_fifo.sv
channel_unit/latency_bridge.sv
channel_unit/src_channel_unit.sv
source/src_sram_controller.sv
tests/src_sram_controller_sva.sv
tests/tb_src_sram_controller.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_src_sram_controller -f all.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASSED" ||
exit 1
